// ==== rtl/aluExec_consts.svh ====
`ifndef ALU_EXEC_CONSTS_SVH
`define ALU_EXEC_CONSTS_SVH

// Datapath word width
`define ALU_DATA_WIDTH 16

// Register file size and index width
`define ALU_REG_COUNT 8
`define ALU_REG_BITS 3

// One Booth step per multiplier bit
`define ALU_MUL_STEPS 16

`endif

// ==== rtl/aluExecPkg.sv ====
`include "aluExec_consts.svh"

package aluExecPkg;

	typedef enum logic [3:0] {
		MOV = 4'h0,
		ADD = 4'h1,
		SUB = 4'h2,
		MUL = 4'h3,
		OR  = 4'h4,
		AND = 4'h5,
		XOR = 4'h6,
		SL  = 4'h7,
		SR  = 4'h8,
		SRA = 4'h9,
		ROT = 4'hA,
		BIT = 4'hB,
		SET = 4'hC,
		CLR = 4'hD,
		CMP = 4'hE,    // SUB without write-back
		SEX = 4'hF
	} aluOpT;

	typedef logic signed [`ALU_DATA_WIDTH-1:0] dataT;
	typedef logic [`ALU_REG_BITS-1:0] regIdxT;

	typedef struct packed {
		logic sign;
		logic carry;
		logic zero;
		logic parity;    // Overflow for arithmetic ops, high half nonzero for MUL
	} flagsT;

	typedef struct packed {
		aluOpT op;
		regIdxT regA;
		regIdxT regB;
		regIdxT regD;
		logic useImm;    // B operand taken from imm
		dataT imm;
	} instrT;

	typedef struct packed {
		dataT value;
		flagsT flags;
		regIdxT regD;
		logic written;    // Low for CMP
	} resultT;

	typedef enum logic [1:0] {IDLE, MULTIPLY, HOLD} execStateT;

endpackage

// ==== rtl/aluCore.sv ====
`timescale 1ns/10ps
`include "aluExec_consts.svh"

module aluCore (
	input aluExecPkg::aluOpT op,
	input aluExecPkg::dataT argA,
	input aluExecPkg::dataT argB,
	output aluExecPkg::dataT value,
	output aluExecPkg::flagsT flags
);

	logic [3:0] amount;
	logic [`ALU_DATA_WIDTH:0] wide;    // Top bit is the carry out
	logic [2*`ALU_DATA_WIDTH-1:0] doubled;
	logic [`ALU_DATA_WIDTH-1:0] bitMask;
	logic [`ALU_DATA_WIDTH-1:0] extMask;
	logic arithmetic;
	logic overflow;

	assign amount = argB[3:0];    // Shift and bit ops use low nibble only
	assign bitMask = `ALU_DATA_WIDTH'(1) << amount;
	assign extMask = {`ALU_DATA_WIDTH{1'b1}} << amount;
	assign doubled = {argA, argA} >> amount;    // Rotate right via doubled word

	always_comb begin
		wide = '0;
		arithmetic = 1'b0;
		value = '0;
		case (op)
			aluExecPkg::MOV: begin
				value = argB;
			end
			aluExecPkg::ADD: begin
				wide = {1'b0, argA} + {1'b0, argB};
				value = wide[`ALU_DATA_WIDTH-1:0];
				arithmetic = 1'b1;
			end
			aluExecPkg::SUB,
			aluExecPkg::CMP: begin
				wide = {1'b0, argA} - {1'b0, argB};    // Borrow lands in bit 16
				value = wide[`ALU_DATA_WIDTH-1:0];
				arithmetic = 1'b1;
			end
			aluExecPkg::MUL: begin
				value = '0;    // Product comes from the Booth unit
			end
			aluExecPkg::OR: begin
				value = argA | argB;
			end
			aluExecPkg::AND: begin
				value = argA & argB;
			end
			aluExecPkg::XOR: begin
				value = argA ^ argB;
			end
			aluExecPkg::SL: begin
				wide = {1'b0, argA} << amount;    // Last bit out ends up in carry
				value = wide[`ALU_DATA_WIDTH-1:0];
			end
			aluExecPkg::SR: begin
				value = argA >> amount;
			end
			aluExecPkg::SRA: begin
				value = argA >>> amount;    // Keeps the sign bit
			end
			aluExecPkg::ROT: begin
				value = doubled[`ALU_DATA_WIDTH-1:0];
			end
			aluExecPkg::BIT: begin
				value = argA & bitMask;
			end
			aluExecPkg::SET: begin
				value = argA | bitMask;
			end
			aluExecPkg::CLR: begin
				value = argA & ~bitMask;
			end
			aluExecPkg::SEX: begin
				// Bit B and everything above it follow bit B
				if (|(argA & bitMask)) begin
					value = argA | extMask;
				end else begin
					value = argA & ~extMask;
				end
				arithmetic = 1'b1;
			end
			default: begin
				value = '1;
			end
		endcase
	end

	// Same-sign operands with a result of the other sign
	assign overflow = (argA[`ALU_DATA_WIDTH-1] == argB[`ALU_DATA_WIDTH-1])
		&& (value[`ALU_DATA_WIDTH-1] != argA[`ALU_DATA_WIDTH-1]);

	assign flags = '{
		sign: value[`ALU_DATA_WIDTH-1],
		carry: wide[`ALU_DATA_WIDTH],
		zero: (value == '0),
		parity: arithmetic ? overflow : value[0]
	};

endmodule

// ==== rtl/boothMultiplier.sv ====
`timescale 1ns/10ps
`include "aluExec_consts.svh"

module boothMultiplier (
	input logic clk,
	input logic reset,
	input logic start,
	input logic step,
	input aluExecPkg::dataT multiplicand,
	input aluExecPkg::dataT multiplier,
	output aluExecPkg::dataT productLow,
	output aluExecPkg::dataT productHigh
);

	localparam int dataWidth = `ALU_DATA_WIDTH;

	// {high half, low half, previous multiplier bit}
	logic [2*dataWidth:0] acc;
	logic [dataWidth-1:0] mcand;
	logic [dataWidth:0] upper;
	logic [dataWidth:0] mcandWide;
	logic [dataWidth:0] partial;    // One bit wider so -32768 never overflows

	assign upper = {acc[2*dataWidth], acc[2*dataWidth:dataWidth+1]};
	assign mcandWide = {mcand[dataWidth-1], mcand};

	always_comb begin
		case (acc[1:0])
			2'b01: partial = upper + mcandWide;    // End of a run of ones
			2'b10: partial = upper - mcandWide;    // Start of a run of ones
			default: partial = upper;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
		end else if (start) begin
			acc <= {{dataWidth{1'b0}}, multiplier, 1'b0};
		end else if (step) begin
			acc <= {partial, acc[dataWidth:1]};    // Arithmetic shift right by one
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			mcand <= multiplicand;
		end
	end

	assign productLow = acc[dataWidth:1];
	assign productHigh = acc[2*dataWidth:dataWidth+1];

endmodule

// ==== rtl/stepCounter.sv ====
`timescale 1ns/10ps
`include "aluExec_consts.svh"

module stepCounter (
	input logic clk,
	input logic reset,
	input logic load,
	input logic step,
	output logic lastStep
);

	localparam int countBits = $clog2(`ALU_MUL_STEPS);

	logic [countBits-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (load) begin
			count <= countBits'(`ALU_MUL_STEPS - 1);
		end else if (step && (count != '0)) begin
			count <= count - 1'b1;
		end
	end

	// Terminal count only counts while stepping
	assign lastStep = step && (count == '0);

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/10ps
`include "aluExec_consts.svh"

module regFile (
	input logic clk,
	input logic reset,
	input aluExecPkg::regIdxT readA,
	input aluExecPkg::regIdxT readB,
	output aluExecPkg::dataT dataA,
	output aluExecPkg::dataT dataB,
	input logic writeEnable,
	input aluExecPkg::regIdxT writeIndex,
	input aluExecPkg::dataT writeData
);

	aluExecPkg::dataT regs [`ALU_REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `ALU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeIndex] <= writeData;
		end
	end

	// Read ports are asynchronous
	assign dataA = regs[readA];
	assign dataB = regs[readB];

endmodule

// ==== rtl/execControl.sv ====
`timescale 1ns/10ps
`include "aluExec_consts.svh"

module execControl (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input aluExecPkg::instrT in,
	output logic outValid,
	input logic outReady,
	output aluExecPkg::resultT out,
	input aluExecPkg::dataT aluValue,
	input aluExecPkg::flagsT aluFlags,
	input aluExecPkg::dataT product,
	input aluExecPkg::dataT productHigh,
	input logic lastStep,
	output logic mulStart,
	output logic mulStep,
	output logic writeEnable,
	output aluExecPkg::regIdxT writeIndex,
	output aluExecPkg::dataT writeData,
	output aluExecPkg::regIdxT readA,
	output aluExecPkg::regIdxT readB,
	output logic useImm,
	output aluExecPkg::dataT imm
);

	aluExecPkg::execStateT state;
	aluExecPkg::regIdxT mulDest;
	aluExecPkg::resultT nextResult;
	logic accept;
	logic isMul;
	logic mulDone;    // Product settled, capture next edge
	logic capture;

	assign inReady = (state == aluExecPkg::IDLE) && (!outValid || outReady);
	assign accept = inValid && inReady;
	assign isMul = (in.op == aluExecPkg::MUL);
	assign mulStart = accept && isMul;
	assign mulStep = (state == aluExecPkg::MULTIPLY) && !mulDone;
	assign capture = (accept && !isMul) || ((state == aluExecPkg::MULTIPLY) && mulDone);

	// Operands are read straight from the offered instruction
	assign readA = in.regA;
	assign readB = in.regB;
	assign useImm = in.useImm;
	assign imm = in.imm;

	always_comb begin
		if (state == aluExecPkg::MULTIPLY) begin
			nextResult.value = product;
			nextResult.flags = '{
				sign: product[`ALU_DATA_WIDTH-1],
				carry: 1'b0,
				zero: (product == '0),
				parity: |productHigh    // Product did not fit in 16 bits
			};
			nextResult.regD = mulDest;
			nextResult.written = 1'b1;
		end else begin
			nextResult.value = aluValue;
			nextResult.flags = aluFlags;
			nextResult.regD = in.regD;
			nextResult.written = (in.op != aluExecPkg::CMP);
		end
	end

	// Write-back lands on the same edge the result is registered
	assign writeEnable = capture && nextResult.written;
	assign writeIndex = nextResult.regD;
	assign writeData = nextResult.value;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= aluExecPkg::HOLD;    // Keeps inReady low through reset
			outValid <= 1'b0;
			mulDone <= 1'b0;
		end else begin
			mulDone <= mulStep && lastStep;
			if (capture) begin
				outValid <= 1'b1;
			end else if (outReady) begin
				outValid <= 1'b0;
			end
			case (state)
				aluExecPkg::IDLE: begin
					if (mulStart) begin
						state <= aluExecPkg::MULTIPLY;
					end else if (outValid && !outReady) begin
						state <= aluExecPkg::HOLD;
					end
				end
				aluExecPkg::MULTIPLY: begin
					if (mulDone) begin
						state <= aluExecPkg::IDLE;
					end
				end
				aluExecPkg::HOLD: begin
					if (!outValid || outReady) begin
						state <= aluExecPkg::IDLE;
					end
				end
				default: begin
					state <= aluExecPkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			out <= nextResult;
		end
		if (mulStart) begin
			mulDest <= in.regD;
		end
	end

endmodule

// ==== rtl/aluExec.sv ====
`timescale 1ns/10ps

module aluExec (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input aluExecPkg::instrT in,
	output logic outValid,
	input logic outReady,
	output aluExecPkg::resultT out
);

	aluExecPkg::dataT dataA;
	aluExecPkg::dataT dataB;
	aluExecPkg::dataT operandB;
	aluExecPkg::dataT imm;
	aluExecPkg::dataT aluValue;
	aluExecPkg::dataT productLow;
	aluExecPkg::dataT productHigh;
	aluExecPkg::dataT writeData;
	aluExecPkg::flagsT aluFlags;
	aluExecPkg::regIdxT readA;
	aluExecPkg::regIdxT readB;
	aluExecPkg::regIdxT writeIndex;
	logic useImm;
	logic mulStart;
	logic mulStep;
	logic lastStep;
	logic writeEnable;

	assign operandB = useImm ? imm : dataB;    // Immediate replaces register B

	execControl u_execControl (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.in(in),
		.outValid(outValid),
		.outReady(outReady),
		.out(out),
		.aluValue(aluValue),
		.aluFlags(aluFlags),
		.product(productLow),
		.productHigh(productHigh),
		.lastStep(lastStep),
		.mulStart(mulStart),
		.mulStep(mulStep),
		.writeEnable(writeEnable),
		.writeIndex(writeIndex),
		.writeData(writeData),
		.readA(readA),
		.readB(readB),
		.useImm(useImm),
		.imm(imm)
	);

	stepCounter u_stepCounter (
		.clk(clk),
		.reset(reset),
		.load(mulStart),
		.step(mulStep),
		.lastStep(lastStep)
	);

	regFile u_regFile (
		.clk(clk),
		.reset(reset),
		.readA(readA),
		.readB(readB),
		.dataA(dataA),
		.dataB(dataB),
		.writeEnable(writeEnable),
		.writeIndex(writeIndex),
		.writeData(writeData)
	);

	aluCore u_aluCore (
		.op(in.op),
		.argA(dataA),
		.argB(operandB),
		.value(aluValue),
		.flags(aluFlags)
	);

	boothMultiplier u_boothMultiplier (
		.clk(clk),
		.reset(reset),
		.start(mulStart),
		.step(mulStep),
		.multiplicand(dataA),
		.multiplier(operandB),
		.productLow(productLow),
		.productHigh(productHigh)
	);

endmodule

// ==== bench/tbClock.sv ====
`timescale 1ns/10ps

module tbClock (
	output logic clk,
	output logic reset
);

	localparam int halfPeriodNs = 4;    // 8 ns clock

	initial begin
		clk = 1'b0;
		forever begin
			#(halfPeriodNs * 1ns);
			clk = ~clk;
		end
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;    // Released just after the second edge
	end

endmodule

// ==== bench/aluExec_properties.sv ====
`timescale 1ns/10ps
`include "aluExec_consts.svh"

module aluExec_properties (
	input logic clk,
	input logic reset,
	input logic inReady,
	input logic outValid,
	input logic outReady,
	input aluExecPkg::resultT out,
	input aluExecPkg::execStateT state
);

	// A stalled result must not change or vanish
	property resultHeld;
		@(posedge clk) disable iff (reset)
		outValid && !outReady |=> outValid && $stable(out);
	endproperty

	// No new instruction while the multiplier runs, product follows the last step
	property busyWhileMultiply;
		@(posedge clk) disable iff (reset)
		$rose(state == aluExecPkg::MULTIPLY) |->
			##(`ALU_MUL_STEPS) ((state == aluExecPkg::MULTIPLY) && !inReady) ##1 outValid;
	endproperty

	property quietAfterReset;
		@(posedge clk)
		reset |=> !outValid && !inReady;
	endproperty

	assert property (resultHeld)
		else $error("outValid or out changed while the result was stalled");
	assert property (busyWhileMultiply)
		else $error("multiply left early, took inputs, or its result did not follow");
	assert property (quietAfterReset)
		else $error("outValid or inReady high right after reset");

endmodule

// ==== bench/aluExec_tb.sv ====
`timescale 1ns/10ps
`include "aluExec_consts.svh"

module aluExec_tb;

	localparam int maxInstr = 16 + 80 + 60 + 24 + 40;    // Worst case over all tests
	localparam int watchdogNs = maxInstr * (`ALU_MUL_STEPS + 8) * 8;

	logic clk;
	logic reset;
	logic inValid;
	logic inReady;
	logic outValid;
	logic outReady;
	logic stallEnable;
	logic [15:0] lfsr = 16'd47;
	int errors = 0;
	int checked = 0;
	int testErrors = 0;
	int testChecked = 0;
	aluExecPkg::instrT instr;
	aluExecPkg::resultT result;
	aluExecPkg::resultT expected [$];
	aluExecPkg::dataT shadow [`ALU_REG_COUNT];
	aluExecPkg::aluOpT arithOps [4] = '{aluExecPkg::ADD, aluExecPkg::SUB,
		aluExecPkg::CMP, aluExecPkg::SEX};
	aluExecPkg::aluOpT logicOps [10] = '{aluExecPkg::OR, aluExecPkg::AND, aluExecPkg::XOR,
		aluExecPkg::SL, aluExecPkg::SR, aluExecPkg::SRA, aluExecPkg::ROT,
		aluExecPkg::BIT, aluExecPkg::SET, aluExecPkg::CLR};

	tbClock u_tbClock (
		.clk(clk),
		.reset(reset)
	);

	aluExec u_aluExec (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.in(instr),
		.outValid(outValid),
		.outReady(outReady),
		.out(result)
	);

	bind execControl aluExec_properties u_aluExecProperties (
		.clk(clk),
		.reset(reset),
		.inReady(inReady),
		.outValid(outValid),
		.outReady(outReady),
		.out(out),
		.state(state)
	);

	// Fibonacci taps 16, 14, 13, 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] randBits(input int n);
		logic [15:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			bits = {bits[14:0], lfsr[0]};
		end
		return bits;
	endfunction

	function automatic aluExecPkg::instrT randInstr(input aluExecPkg::aluOpT op);
		aluExecPkg::instrT ins;
		ins.op = op;
		ins.regA = aluExecPkg::regIdxT'(randBits(3));
		ins.regB = aluExecPkg::regIdxT'(randBits(3));
		ins.regD = aluExecPkg::regIdxT'(randBits(3));
		ins.useImm = (randBits(1) != 0);
		ins.imm = randBits(16);
		return ins;
	endfunction

	// Expected result worked out from the operation rules
	function automatic aluExecPkg::resultT refResult(input aluExecPkg::instrT ins,
			input logic [15:0] a, input logic [15:0] b);
		aluExecPkg::resultT r;
		logic [15:0] v;
		logic [3:0] n;
		logic signed [31:0] prod;
		logic carry;
		logic arith;
		int ua;
		int ub;
		int tmp;
		n = b[3:0];
		ua = int'(a);
		ub = int'(b);
		v = '0;
		carry = 1'b0;
		arith = 1'b0;
		prod = '0;
		case (ins.op)
			aluExecPkg::MOV: v = b;
			aluExecPkg::ADD: begin
				tmp = ua + ub;
				v = tmp[15:0];
				carry = (tmp > 65535);
				arith = 1'b1;
			end
			aluExecPkg::SUB, aluExecPkg::CMP: begin
				tmp = ua - ub;
				v = tmp[15:0];
				carry = (ua < ub);    // Borrow
				arith = 1'b1;
			end
			aluExecPkg::MUL: begin
				prod = 32'($signed(a)) * 32'($signed(b));
				v = prod[15:0];
			end
			aluExecPkg::OR: v = a | b;
			aluExecPkg::AND: v = a & b;
			aluExecPkg::XOR: v = a ^ b;
			aluExecPkg::SL: begin
				v = a << n;
				if (n != 0) begin
					carry = a[16 - n];    // Last bit pushed out
				end
			end
			aluExecPkg::SR: v = a >> n;
			aluExecPkg::SRA: v = $signed(a) >>> n;
			aluExecPkg::ROT: v = (a >> n) | (a << (16 - n));
			aluExecPkg::BIT: v = a & (16'd1 << n);
			aluExecPkg::SET: v = a | (16'd1 << n);
			aluExecPkg::CLR: v = a & ~(16'd1 << n);
			aluExecPkg::SEX: begin
				v = a;
				for (int i = 0; i < 16; i++) begin
					if (i > n) begin
						v[i] = a[n];
					end
				end
				arith = 1'b1;
			end
		endcase
		r.value = v;
		r.flags.sign = v[15];
		r.flags.carry = carry;
		r.flags.zero = (v == '0);
		if (ins.op == aluExecPkg::MUL) begin
			r.flags.parity = (prod[31:16] != '0);
		end else if (arith) begin
			r.flags.parity = (a[15] == b[15]) && (v[15] != a[15]);
		end else begin
			r.flags.parity = v[0];
		end
		r.regD = ins.regD;
		r.written = (ins.op != aluExecPkg::CMP);
		return r;
	endfunction

	task automatic checkValue(input string name, input aluExecPkg::dataT got,
			input aluExecPkg::dataT exp);
		if (got !== exp) begin
			errors++;
			$display("error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic checkFlags(input string name, input aluExecPkg::flagsT got,
			input aluExecPkg::flagsT exp);
		if (got !== exp) begin
			errors++;
			$display("error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic checkDest(input string name, input aluExecPkg::regIdxT got,
			input aluExecPkg::regIdxT exp);
		if (got !== exp) begin
			errors++;
			$display("error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic checkWritten(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// Offer one instruction and book its expected result once it is taken
	task automatic issue(input aluExecPkg::instrT ins);
		aluExecPkg::resultT r;
		instr = ins;
		inValid = 1'b1;
		do begin
			@(negedge clk);
		end while (!inReady);
		r = refResult(ins, shadow[ins.regA], ins.useImm ? ins.imm : shadow[ins.regB]);
		if (r.written) begin
			shadow[r.regD] = r.value;
		end
		expected.push_back(r);
		@(posedge clk);
		#1;
	endtask

	task automatic endTest(input int num, input string name);
		inValid = 1'b0;
		while (expected.size() != 0) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;    // Next test drives just after the edge
		$display("Test %0d %s: %0d results, %0d errors", num, name,
			checked - testChecked, errors - testErrors);
		testChecked = checked;
		testErrors = errors;
	endtask

	always @(negedge clk) begin : compareResults
		aluExecPkg::resultT exp;
		if (!reset && outValid && outReady) begin
			if (expected.size() == 0) begin
				errors++;
				$display("Result 0x%h came out with no instruction pending", result);
			end else begin
				exp = expected.pop_front();
				checkValue("out.value", result.value, exp.value);
				checkFlags("out.flags", result.flags, exp.flags);
				checkDest("out.regD", result.regD, exp.regD);
				checkWritten("out.written", result.written, exp.written);
				checked++;
			end
		end
	end

	// Random sink stalls, drawn between edges
	initial begin : stallOutput
		logic stall;
		outReady = 1'b1;
		forever begin
			@(negedge clk);
			stall = stallEnable && (randBits(1) != 0);
			@(posedge clk);
			#1;
			outReady = !stall;
		end
	end

	initial begin : watchdog
		#(watchdogNs * 1ns);
		$display("Run stopped by the watchdog after %0d ns, %0d results still pending",
			watchdogNs, expected.size());
		$display("TEST FAILED");
		$finish;
	end

	initial begin : mainSequence
		aluExecPkg::instrT ins;
		aluExecPkg::regIdxT prevDest;
		inValid = 1'b0;
		instr = '0;
		stallEnable = 1'b0;
		prevDest = '0;
		foreach (shadow[i]) begin
			shadow[i] = '0;    // Registers clear on reset
		end
		@(negedge reset);
		@(posedge clk);
		#1;

		for (int i = 0; i < `ALU_REG_COUNT; i++) begin
			ins = randInstr(aluExecPkg::MOV);
			ins.regD = aluExecPkg::regIdxT'(i);
			ins.useImm = 1'b1;
			issue(ins);
		end
		for (int i = 0; i < `ALU_REG_COUNT; i++) begin
			ins = randInstr(aluExecPkg::MOV);
			ins.useImm = 1'b0;
			issue(ins);
		end
		endTest(1, "register load and MOV");

		for (int i = 0; i < 40; i++) begin
			ins = randInstr(arithOps[randBits(2)]);
			issue(ins);
			if (ins.op == aluExecPkg::CMP) begin
				ins.op = aluExecPkg::MOV;    // Read back the CMP target
				ins.regB = ins.regD;
				ins.useImm = 1'b0;
				ins.regD = aluExecPkg::regIdxT'(randBits(3));
				issue(ins);
			end
		end
		endTest(2, "arithmetic and compare");

		for (int i = 0; i < 60; i++) begin
			ins = randInstr(logicOps[randBits(4) % 10]);
			if (i % 10 == 0) begin
				ins.useImm = 1'b1;
				ins.imm[3:0] = (i % 20 == 0) ? 4'd0 : 4'd15;
			end
			issue(ins);
		end
		endTest(3, "logic and bit operations");

		ins = randInstr(aluExecPkg::MOV);
		ins.regD = 3'd1;
		ins.useImm = 1'b1;
		ins.imm = 16'sh8000;
		issue(ins);
		ins.op = aluExecPkg::MUL;
		ins.regA = 3'd1;
		ins.regD = 3'd2;
		issue(ins);    // -32768 squared
		ins.imm = '0;
		ins.regD = 3'd3;
		issue(ins);
		ins.useImm = 1'b0;
		ins.regB = 3'd1;
		ins.regD = 3'd4;
		issue(ins);
		for (int i = 0; i < 20; i++) begin
			issue(randInstr(aluExecPkg::MUL));
		end
		endTest(4, "multiply");

		stallEnable = 1'b1;
		for (int i = 0; i < 40; i++) begin
			ins = randInstr(aluExecPkg::aluOpT'(4'(randBits(4))));
			ins.regA = prevDest;    // Reads the register just written
			prevDest = ins.regD;
			issue(ins);
		end
		endTest(5, "back-pressure and dependencies");
		stallEnable = 1'b0;

		$display("Summary: %0d results checked, %0d errors", checked, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/aluExecPkg.sv
rtl/aluCore.sv
rtl/boothMultiplier.sv
rtl/stepCounter.sv
rtl/regFile.sv
rtl/execControl.sv
rtl/aluExec.sv
bench/tbClock.sv
bench/aluExec_properties.sv
bench/aluExec_tb.sv

// ==== Bender.yml ====
package:
  name: alu_exec

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/aluExecPkg.sv
      - rtl/aluCore.sv
      - rtl/boothMultiplier.sv
      - rtl/stepCounter.sv
      - rtl/regFile.sv
      - rtl/execControl.sv
      - rtl/aluExec.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/tbClock.sv
      - bench/aluExec_properties.sv
      - bench/aluExec_tb.sv
